/* common/main_consts.svh */
`ifndef MAIN_CONSTS_SVH
`define MAIN_CONSTS_SVH

// load value of the ROM access delay counter
`define ROM_CYCLE_LEN 6

// about 1ms of CPU clock silence, in CLK2 cycles
`define SNES_DEAD_TIMEOUT 80000

// strobe shift registers and address pipeline
`define SYNC_DEPTH 8
`define ADDR_SYNC_DEPTH 7

////////////////////
// edge patterns, oldest sample on the left

`define EDGE_PAT_W 6
`define EDGE_FALL 6'b111110
`define EDGE_RISE 6'b000001

`endif

/* common/rom_arb_pkg.sv */
package rom_arb_pkg;

  ////////////////////
  // arbiter side types

  // byte address into ROM, bit 0 is the lane select
  typedef logic [23:0] rom_addr_t;

  typedef enum logic [2:0] {
    idle,
    mcu_rd_addr, // ROM cycle running for an mcu read
    mcu_rd_end,
    mcu_wr_addr, // write enable held low here
    mcu_wr_end
  } arb_state_e;

  // who drives the ROM address right now
  typedef enum logic [1:0] {
    snes,
    mcu_rd,
    mcu_wr
  } rom_owner_e;

endpackage

/* common/snes_bus_if.sv */
// synchronized console bus, one driver, several readers
interface snes_bus_if;
  snes_bus_pkg::snes_addr_t addr;
  logic read;        // filtered /RD level
  logic write;       // filtered /WR level
  logic cpu_clk;
  logic rd_start;
  logic rd_end;
  logic wr_end;
  logic cycle_start; // cpu clock rising
  logic cycle_end;   // cpu clock falling

  modport src (output addr, read, write, cpu_clk,
               output rd_start, rd_end, wr_end, cycle_start, cycle_end);
  modport snk (input addr, read, write, cpu_clk,
               input rd_start, rd_end, wr_end, cycle_start, cycle_end);
endinterface

// arbiter <-> ROM port select lines
interface rom_sel_if;
  rom_arb_pkg::rom_owner_e  owner;
  rom_arb_pkg::rom_addr_t   mcu_addr;
  snes_bus_pkg::snes_byte_t mcu_dout_q; // mcu write byte
  snes_bus_pkg::snes_byte_t lane_byte;  // ROM byte on the selected lane

  modport arb  (output owner, mcu_addr, mcu_dout_q, input lane_byte);
  modport port (input owner, mcu_addr, mcu_dout_q, output lane_byte);
endinterface

/* common/snes_bus_pkg.sv */
package snes_bus_pkg;

  ////////////////////
  // console side types

  // full 24 bit bank:offset address as seen on the cart edge
  typedef logic [23:0] snes_addr_t;

  typedef logic [7:0] snes_byte_t; // console data bus

  // cartridge memory layout
  typedef enum logic {
    lorom = 1'b0, // 32k banks, upper half of each bank
    hirom = 1'b1  // 64k banks, linear
  } mapper_e;

endpackage

/* hw/address_map.sv */
module address_map (
  snes_bus_if.snk                 bus,
  input  snes_bus_pkg::mapper_e   mapper,
  input  rom_arb_pkg::rom_addr_t  rom_mask,
  output logic                    rom_hit,
  output rom_arb_pkg::rom_addr_t  rom_addr
);

  logic                   lorom_hit;
  logic                   hirom_hit;
  rom_arb_pkg::rom_addr_t lorom_addr;
  rom_arb_pkg::rom_addr_t hirom_addr;

  ////////////////////
  // hirom

  // banks 40-7f and c0-ff fully, upper half of the others
  assign hirom_hit  = bus.addr[22] | bus.addr[15];
  assign hirom_addr = {2'b00, bus.addr[21:0]};

  ////////////////////
  // lorom

  assign lorom_hit  = bus.addr[15]; // $8000-$ffff in every bank
  // A15 dropped, banks pack 32k each
  assign lorom_addr = {2'b00, bus.addr[22:16], bus.addr[14:0]};

  assign rom_hit  = (mapper == snes_bus_pkg::hirom) ? hirom_hit : lorom_hit;
  assign rom_addr = ((mapper == snes_bus_pkg::hirom) ? hirom_addr : lorom_addr) & rom_mask;

endmodule

/* hw/main_top.sv */
module main_top (
  input  logic                     clk2,
  input  logic                     rst_n,
  // console side
  input  snes_bus_pkg::snes_addr_t snes_addr_in,
  input  logic                     snes_read_in,
  input  logic                     snes_write_in,
  input  logic                     snes_cpu_clk_in,
  input  snes_bus_pkg::snes_byte_t snes_data_in,
  output snes_bus_pkg::snes_byte_t snes_data_out,
  output logic                     snes_data_oe,
  // mapping setup
  input  snes_bus_pkg::mapper_e    mapper,
  input  rom_arb_pkg::rom_addr_t   rom_mask,
  // mcu handshake
  input  logic                     mcu_rrq,
  input  logic                     mcu_wrq,
  input  rom_arb_pkg::rom_addr_t   mcu_addr,
  input  snes_bus_pkg::snes_byte_t mcu_dout,
  output logic                     mcu_rdy,
  output snes_bus_pkg::snes_byte_t mcu_din,
  // 16 bit ROM
  output logic [22:0]              rom_addr,
  input  logic [15:0]              rom_data_in,
  output logic [15:0]              rom_data_out,
  output logic                     rom_data_oe,
  output logic                     rom_we,
  output logic                     rom_bhe,
  output logic                     rom_ble
);

  snes_bus_if bus ();
  rom_sel_if  sel ();

  logic                   rom_hit;
  rom_arb_pkg::rom_addr_t mapped_addr;
  logic                   dead;
  logic                   alive_edge;
  logic                   free_slot;

  snes_bus_sync i_sync (
    .clk2            (clk2),
    .rst_n           (rst_n),
    .snes_addr_in    (snes_addr_in),
    .snes_read_in    (snes_read_in),
    .snes_write_in   (snes_write_in),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .bus             (bus.src)
  );

  snes_liveness i_liveness (
    .clk2       (clk2),
    .rst_n      (rst_n),
    .bus        (bus.snk),
    .rom_hit    (rom_hit),
    .dead       (dead),
    .alive_edge (alive_edge),
    .free_slot  (free_slot)
  );

  address_map i_map (
    .bus      (bus.snk),
    .mapper   (mapper),
    .rom_mask (rom_mask),
    .rom_hit  (rom_hit),
    .rom_addr (mapped_addr)
  );

  rom_arbiter i_arb (
    .clk2       (clk2),
    .rst_n      (rst_n),
    .mcu_rrq    (mcu_rrq),
    .mcu_wrq    (mcu_wrq),
    .mcu_addr   (mcu_addr),
    .mcu_dout   (mcu_dout),
    .free_slot  (free_slot),
    .dead       (dead),
    .alive_edge (alive_edge),
    .mcu_rdy    (mcu_rdy),
    .mcu_din    (mcu_din),
    .sel        (sel.arb)
  );

  rom_port i_port (
    .bus           (bus.snk),
    .sel           (sel.port),
    .snes_rom_addr (mapped_addr),
    .rom_hit       (rom_hit),
    .snes_data_in  (snes_data_in),
    .rom_addr      (rom_addr),
    .rom_data_in   (rom_data_in),
    .rom_data_out  (rom_data_out),
    .rom_data_oe   (rom_data_oe),
    .rom_we        (rom_we),
    .rom_bhe       (rom_bhe),
    .rom_ble       (rom_ble),
    .snes_data_out (snes_data_out),
    .snes_data_oe  (snes_data_oe)
  );

endmodule

/* hw/rom_arb/rom_arbiter.sv */
`include "main_consts.svh"

module rom_arbiter (
  input  logic                     clk2,
  input  logic                     rst_n,
  input  logic                     mcu_rrq,
  input  logic                     mcu_wrq,
  input  rom_arb_pkg::rom_addr_t   mcu_addr,
  input  snes_bus_pkg::snes_byte_t mcu_dout,
  input  logic                     free_slot,
  input  logic                     dead,
  input  logic                     alive_edge,
  output logic                     mcu_rdy,
  output snes_bus_pkg::snes_byte_t mcu_din,
  rom_sel_if.arb                   sel
);

  localparam int delay_w = $clog2(`ROM_CYCLE_LEN + 1);

  rom_arb_pkg::arb_state_e  state;
  logic [delay_w-1:0]       delay_cnt;
  logic                     rd_pend;
  logic                     wr_pend;
  logic                     access_end;
  rom_arb_pkg::rom_addr_t   addr_q;
  snes_bus_pkg::snes_byte_t dout_q;

  assign access_end = (state == rom_arb_pkg::mcu_rd_end) ||
                      (state == rom_arb_pkg::mcu_wr_end);

  ////////////////////
  // request capture

  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rrq) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (access_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge clk2) begin
    if (mcu_rrq || mcu_wrq) begin
      addr_q <= mcu_addr;
      dout_q <= mcu_dout;
    end
  end

  ////////////////////
  // access FSM

  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      state     <= rom_arb_pkg::idle;
      delay_cnt <= '0;
    end else if (alive_edge) begin
      state <= rom_arb_pkg::idle; // console woke up, pending access is retried
    end else begin
      case (state)
        rom_arb_pkg::idle: begin
          if (free_slot || dead) begin
            if (rd_pend) begin
              state     <= rom_arb_pkg::mcu_rd_addr;
              delay_cnt <= delay_w'(`ROM_CYCLE_LEN);
            end else if (wr_pend) begin
              state     <= rom_arb_pkg::mcu_wr_addr;
              delay_cnt <= delay_w'(`ROM_CYCLE_LEN);
            end
          end
        end
        rom_arb_pkg::mcu_rd_addr, rom_arb_pkg::mcu_wr_addr: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) begin
            state <= (state == rom_arb_pkg::mcu_rd_addr) ? rom_arb_pkg::mcu_rd_end
                                                         : rom_arb_pkg::mcu_wr_end;
          end
        end
        default: state <= rom_arb_pkg::idle; // end states
      endcase
    end
  end

  // last sample of the address state wins
  always_ff @(posedge clk2) begin
    if (state == rom_arb_pkg::mcu_rd_addr) begin
      mcu_din <= sel.lane_byte;
    end
  end

  // end states hand the bus back to the console
  assign sel.owner = (state == rom_arb_pkg::mcu_rd_addr) ? rom_arb_pkg::mcu_rd :
                     (state == rom_arb_pkg::mcu_wr_addr) ? rom_arb_pkg::mcu_wr :
                     rom_arb_pkg::snes;
  assign sel.mcu_addr   = addr_q;
  assign sel.mcu_dout_q = dout_q;

  a_rdy_low_while_pending : assert property (
    @(posedge clk2) disable iff (!rst_n) (rd_pend || wr_pend) |-> !mcu_rdy);

  // one request in flight, issued only while ready
  a_req_only_when_ready : assert property (
    @(posedge clk2) disable iff (!rst_n) (mcu_rrq || mcu_wrq) |-> mcu_rdy);

endmodule

/* hw/rom_arb/rom_port.sv */
module rom_port (
  snes_bus_if.snk                  bus,
  rom_sel_if.port                  sel,
  input  rom_arb_pkg::rom_addr_t   snes_rom_addr,
  input  logic                     rom_hit,
  input  snes_bus_pkg::snes_byte_t snes_data_in,
  output logic [22:0]              rom_addr,
  input  logic [15:0]              rom_data_in,
  output logic [15:0]              rom_data_out,
  output logic                     rom_data_oe,
  output logic                     rom_we,
  output logic                     rom_bhe,
  output logic                     rom_ble,
  output snes_bus_pkg::snes_byte_t snes_data_out,
  output logic                     snes_data_oe
);

  rom_arb_pkg::rom_addr_t   byte_addr;
  snes_bus_pkg::snes_byte_t wr_byte;
  logic                     snes_owns;
  logic                     mcu_wr_own;
  logic                     snes_wr_hit;

  assign snes_owns   = sel.owner == rom_arb_pkg::snes;
  assign mcu_wr_own  = sel.owner == rom_arb_pkg::mcu_wr;
  assign snes_wr_hit = snes_owns & rom_hit & ~bus.write;

  ////////////////////
  // address and lanes

  assign byte_addr = snes_owns ? snes_rom_addr : sel.mcu_addr;
  assign rom_addr  = byte_addr[23:1]; // word address
  assign rom_bhe   = byte_addr[0];    // active low, odd byte sits on the low lane
  assign rom_ble   = ~byte_addr[0];

  assign sel.lane_byte = byte_addr[0] ? rom_data_in[7:0] : rom_data_in[15:8];

  ////////////////////
  // write path

  assign wr_byte      = mcu_wr_own ? sel.mcu_dout_q : snes_data_in;
  assign rom_data_out = byte_addr[0] ? {8'h00, wr_byte} : {wr_byte, 8'h00};
  assign rom_data_oe  = snes_wr_hit | mcu_wr_own;

  // console writes only while the cpu clock is high
  assign rom_we = ~((snes_wr_hit & bus.cpu_clk) | mcu_wr_own);

  // console read data
  assign snes_data_oe  = rom_hit & ~bus.read;
  assign snes_data_out = sel.lane_byte;

endmodule

/* hw/snes_bus/snes_bus_sync.sv */
`include "main_consts.svh"

module snes_bus_sync (
  input  logic                     clk2,
  input  logic                     rst_n,
  input  snes_bus_pkg::snes_addr_t snes_addr_in,
  input  logic                     snes_read_in,
  input  logic                     snes_write_in,
  input  logic                     snes_cpu_clk_in,
  snes_bus_if.src                  bus
);

  // the address is taken from the last two stages
  localparam int addr_stages = `ADDR_SYNC_DEPTH - 2;

  logic [`SYNC_DEPTH-1:0] read_sr;
  logic [`SYNC_DEPTH-1:0] write_sr;
  logic [`SYNC_DEPTH-1:0] cpu_clk_sr;
  snes_bus_pkg::snes_addr_t addr_pipe [addr_stages];

  ////////////////////
  // pin sampling

  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      read_sr    <= '1; // strobes idle high
      write_sr   <= '1;
      cpu_clk_sr <= '0;
    end else begin
      read_sr    <= {read_sr[`SYNC_DEPTH-2:0], snes_read_in};
      write_sr   <= {write_sr[`SYNC_DEPTH-2:0], snes_write_in};
      cpu_clk_sr <= {cpu_clk_sr[`SYNC_DEPTH-2:0], snes_cpu_clk_in};
    end
  end

  always_ff @(posedge clk2) begin
    addr_pipe[0] <= snes_addr_in;
    for (int i = 1; i < addr_stages; i++) begin
      addr_pipe[i] <= addr_pipe[i-1];
    end
  end

  // asserted only when both newest stages agree
  assign bus.read    = read_sr[1] | read_sr[0];
  assign bus.write   = write_sr[1] | write_sr[0];
  assign bus.cpu_clk = cpu_clk_sr[1] & cpu_clk_sr[0];
  assign bus.addr    = addr_pipe[addr_stages-1] & addr_pipe[addr_stages-2];

  ////////////////////
  // cycle events

  assign bus.rd_start    = read_sr[`SYNC_DEPTH-1 -: `EDGE_PAT_W] == `EDGE_FALL;
  assign bus.rd_end      = read_sr[`SYNC_DEPTH-1 -: `EDGE_PAT_W] == `EDGE_RISE;
  assign bus.wr_end      = write_sr[`SYNC_DEPTH-1 -: `EDGE_PAT_W] == `EDGE_RISE;
  assign bus.cycle_start = cpu_clk_sr[`SYNC_DEPTH-1 -: `EDGE_PAT_W] == `EDGE_RISE;
  assign bus.cycle_end   = cpu_clk_sr[`SYNC_DEPTH-1 -: `EDGE_PAT_W] == `EDGE_FALL;

  a_rd_edges_exclusive : assert property (
    @(posedge clk2) disable iff (!rst_n) !(bus.rd_start && bus.rd_end));

endmodule

/* hw/snes_bus/snes_liveness.sv */
`include "main_consts.svh"

module snes_liveness (
  input  logic    clk2,
  input  logic    rst_n,
  snes_bus_if.snk bus,
  input  logic    rom_hit,
  output logic    dead,
  output logic    alive_edge,
  output logic    free_slot
);

  localparam int cnt_w = $clog2(`SNES_DEAD_TIMEOUT + 2);

  logic [cnt_w-1:0] dead_cnt;
  logic             free_strobe;

  // low time of the cpu clock, stops just past the timeout
  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      dead_cnt <= '0;
    end else if (bus.cpu_clk) begin
      dead_cnt <= '0;
    end else if (dead_cnt <= cnt_w'(`SNES_DEAD_TIMEOUT)) begin
      dead_cnt <= dead_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      dead       <= 1'b1; // no console until a clock shows up
      alive_edge <= 1'b0;
    end else begin
      alive_edge <= dead & bus.cpu_clk;
      if (bus.cpu_clk) begin
        dead <= 1'b0;
      end else if (dead_cnt > cnt_w'(`SNES_DEAD_TIMEOUT)) begin
        dead <= 1'b1;
      end
    end
  end

  // cycle that does not touch ROM leaves the bus to the mcu
  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= bus.cycle_start & ~rom_hit;
    end
  end

  assign free_slot = bus.cycle_end | free_strobe;

endmodule

/* list.f */
+incdir+common
common/snes_bus_pkg.sv
common/rom_arb_pkg.sv
common/snes_bus_if.sv
hw/snes_bus/snes_bus_sync.sv
hw/snes_bus/snes_liveness.sv
hw/address_map.sv
hw/rom_arb/rom_arbiter.sv
hw/rom_arb/rom_port.sv
hw/main_top.sv
sim/tb_main.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert --top-module tb_main \
    -f list.f -Mdir obj_dir -o tb_main; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/tb_main > "$log" 2>&1; then
  cat "$log"
  echo "simulation exited with an error"
  exit 1
fi

cat "$log"

# the log decides pass or fail
if grep -q "Something failed" "$log"; then
  exit 1
fi

exit 0

/* sim/tb_main.sv */
module tb_main;

  localparam int seed_init    = 57610;
  localparam int rom_words    = 65536;
  localparam int cpu_half     = 6;    // clk2 cycles per cpu clock phase
  localparam int read_settle  = 6;    // address needs 5 cycles through the pipeline
  localparam int access_limit = 200;  // clk2 cycles allowed for one mcu access
  localparam int n_tests      = 5;
  localparam int worst_test   = 1000; // clk2 cycles, a few accesses per test
  localparam int dead_timeout = 80000;
  localparam int watchdog_time = 8 * (n_tests * worst_test + dead_timeout);

  localparam rom_arb_pkg::rom_addr_t   test_mask   = 24'h01ffff; // 64k words in the model
  localparam rom_arb_pkg::rom_addr_t   wr_addr     = 24'h004a20;
  localparam rom_arb_pkg::rom_addr_t   wr_addr_odd = 24'h004a21;
  localparam rom_arb_pkg::rom_addr_t   live_addr   = 24'h007777;
  localparam snes_bus_pkg::snes_addr_t lo_addr     = 24'h259234; // bank bits cut by the mask
  localparam snes_bus_pkg::snes_addr_t hi_addr     = 24'hc72345;
  localparam snes_bus_pkg::snes_addr_t miss_addr   = 24'h011234; // A15 low, no lorom hit

  logic                     clk2 = 1'b0;
  logic                     rst_n;
  snes_bus_pkg::snes_addr_t snes_addr_in;
  logic                     snes_read_in;
  logic                     snes_write_in;
  logic                     snes_cpu_clk_in = 1'b0;
  snes_bus_pkg::snes_byte_t snes_data_in;
  snes_bus_pkg::snes_byte_t snes_data_out;
  logic                     snes_data_oe;
  snes_bus_pkg::mapper_e    mapper;
  rom_arb_pkg::rom_addr_t   rom_mask;
  logic                     mcu_rrq;
  logic                     mcu_wrq;
  rom_arb_pkg::rom_addr_t   mcu_addr;
  snes_bus_pkg::snes_byte_t mcu_dout;
  logic                     mcu_rdy;
  snes_bus_pkg::snes_byte_t mcu_din;
  logic [22:0]              rom_addr;
  logic [15:0]              rom_data_in;
  logic [15:0]              rom_data_out;
  logic                     rom_data_oe;
  logic                     rom_we;
  logic                     rom_bhe;
  logic                     rom_ble;

  logic [15:0]              rom_mem [rom_words];
  snes_bus_pkg::snes_byte_t wr_data [2];
  logic                     cpu_run;
  int                       cpu_div = 0;
  int                       we_fall_count = 0;
  int                       err_count;
  int                       n_checks;
  int                       seed;

  main_top i_dut (.*);

  always #4 clk2 = ~clk2;

  ////////////////////
  // board models

  // 16 bit ROM, lane enables active low
  assign rom_data_in = rom_mem[rom_addr[15:0]];

  always @(posedge clk2) begin
    if (!rst_n) begin
      for (int i = 0; i < rom_words; i++) begin
        rom_mem[i] <= 16'(i * 40503 + 4660);
      end
    end else if (!rom_we) begin
      if (!rom_bhe) rom_mem[rom_addr[15:0]][15:8] <= rom_data_out[15:8];
      if (!rom_ble) rom_mem[rom_addr[15:0]][7:0] <= rom_data_out[7:0];
    end
  end

  always @(posedge clk2) begin
    if (cpu_run) begin
      if (cpu_div == cpu_half - 1) begin
        cpu_div         <= 0;
        snes_cpu_clk_in <= ~snes_cpu_clk_in;
      end else begin
        cpu_div <= cpu_div + 1;
      end
    end
  end

  // write strobe seen while the console reads
  always @(negedge clk2) begin
    if (rst_n && !snes_read_in && !rom_we) we_fall_count <= we_fall_count + 1;
  end

  ////////////////////
  // expected values

  // 32k per bank, A15 is not part of the ROM address
  function automatic rom_arb_pkg::rom_addr_t lorom_map(input snes_bus_pkg::snes_addr_t a);
    rom_arb_pkg::rom_addr_t bank;
    rom_arb_pkg::rom_addr_t offset;
    bank   = 24'(a[22:16]);
    offset = 24'(a[14:0]);
    return (bank * 24'h008000 + offset) & test_mask;
  endfunction

  // linear 4M window
  function automatic rom_arb_pkg::rom_addr_t hirom_map(input snes_bus_pkg::snes_addr_t a);
    return (a % 24'h400000) & test_mask;
  endfunction

  // odd bytes live on the low lane
  function automatic snes_bus_pkg::snes_byte_t model_byte(input rom_arb_pkg::rom_addr_t a);
    logic [15:0] word;
    word = rom_mem[a[16:1]];
    return a[0] ? word[7:0] : word[15:8];
  endfunction

  task automatic check_flag(input string name, input logic expected, input logic actual);
    n_checks++;
    if (actual !== expected) begin
      err_count++;
      $display("FAILED %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic check_byte(input string name, input snes_bus_pkg::snes_byte_t expected,
                            input snes_bus_pkg::snes_byte_t actual);
    n_checks++;
    if (actual !== expected) begin
      err_count++;
      $display("FAILED %s: expected %02h, actual %02h", name, expected, actual);
    end
  endtask

  task automatic check_rom_addr(input string name, input rom_arb_pkg::rom_addr_t expected,
                                input rom_arb_pkg::rom_addr_t actual);
    n_checks++;
    if (actual !== expected) begin
      err_count++;
      $display("FAILED %s: expected %06h, actual %06h", name, expected, actual);
    end
  endtask

  ////////////////////
  // mcu handshake

  task automatic issue_request(input bit is_write, input rom_arb_pkg::rom_addr_t addr,
                               input snes_bus_pkg::snes_byte_t data);
    @(posedge clk2);
    mcu_addr <= addr;
    mcu_dout <= data;
    mcu_rrq  <= !is_write;
    mcu_wrq  <= is_write;
    @(posedge clk2);
    mcu_rrq <= 1'b0; // one cycle pulse
    mcu_wrq <= 1'b0;
  endtask

  task automatic wait_ready(input string name, output bit done, output bit we_seen,
                            output rom_arb_pkg::rom_addr_t we_addr, output logic we_oe);
    int cycles;
    cycles  = 0;
    we_seen = 1'b0;
    we_addr = '0;
    we_oe   = 1'b0;
    @(negedge clk2);
    check_flag({name, " rdy low"}, 1'b0, mcu_rdy);
    while (!mcu_rdy && cycles < access_limit) begin
      if (!rom_we && !we_seen) begin
        we_seen = 1'b1;
        we_addr = {rom_addr, rom_bhe}; // bhe follows byte address bit 0
        we_oe   = rom_data_oe;
      end
      @(negedge clk2);
      cycles++;
    end
    done = mcu_rdy;
    if (!done) begin
      err_count++;
      $display("%s: mcu_rdy did not rise within %0d cycles", name, access_limit);
    end
  endtask

  task automatic mcu_write(input string name, input rom_arb_pkg::rom_addr_t addr,
                           input snes_bus_pkg::snes_byte_t data);
    bit                     done;
    bit                     we_seen;
    rom_arb_pkg::rom_addr_t we_addr;
    logic                   we_oe;
    logic [15:0]            old_word;
    logic [15:0]            new_word;
    old_word = rom_mem[addr[16:1]];
    issue_request(1'b1, addr, data);
    wait_ready(name, done, we_seen, we_addr, we_oe);
    if (done && !we_seen) begin
      err_count++;
      $display("%s: rom_we never went low during the write", name);
    end else if (done) begin
      check_rom_addr({name, " addr"}, addr, we_addr);
      check_flag({name, " data oe"}, 1'b1, we_oe);
      new_word = rom_mem[addr[16:1]];
      check_byte({name, " lane"}, data, addr[0] ? new_word[7:0] : new_word[15:8]);
      check_byte({name, " other lane"}, addr[0] ? old_word[15:8] : old_word[7:0],
                 addr[0] ? new_word[15:8] : new_word[7:0]);
    end
  endtask

  task automatic mcu_read(input string name, input rom_arb_pkg::rom_addr_t addr,
                          input snes_bus_pkg::snes_byte_t expected);
    bit                     done;
    bit                     we_seen;
    rom_arb_pkg::rom_addr_t we_addr;
    logic                   we_oe;
    issue_request(1'b0, addr, 8'h00);
    wait_ready(name, done, we_seen, we_addr, we_oe);
    if (we_seen) begin
      err_count++;
      $display("%s: rom_we went low during an mcu read", name);
    end
    if (done) check_byte(name, expected, mcu_din);
  endtask

  ////////////////////
  // console side

  task automatic console_read(input string name, input snes_bus_pkg::snes_addr_t addr,
                              input logic hit, input rom_arb_pkg::rom_addr_t exp_addr);
    @(posedge clk2);
    snes_addr_in <= addr;
    snes_read_in <= 1'b0;
    repeat (read_settle) @(posedge clk2);
    @(negedge clk2);
    check_flag({name, " oe"}, hit, snes_data_oe);
    check_flag({name, " rom oe"}, 1'b0, rom_data_oe);
    if (hit) begin
      check_rom_addr({name, " rom addr"}, exp_addr, {rom_addr, rom_bhe});
      check_byte({name, " data"}, model_byte(exp_addr), snes_data_out);
    end
    @(posedge clk2);
    snes_read_in <= 1'b1;
    repeat (read_settle) @(posedge clk2);
    @(negedge clk2);
    check_flag({name, " oe released"}, 1'b0, snes_data_oe);
  endtask

  task automatic console_traffic(input int n_reads);
    repeat (n_reads) begin
      @(posedge clk2);
      snes_addr_in <= lo_addr;
      snes_read_in <= 1'b0;
      repeat (8) @(posedge clk2);
      snes_read_in <= 1'b1;
      repeat (4) @(posedge clk2);
    end
  endtask

  ////////////////////
  // tests

  task automatic reset_values;
    @(negedge clk2);
    check_flag("reset mcu_rdy", 1'b1, mcu_rdy);
    check_flag("reset rom_we", 1'b1, rom_we);
    check_flag("reset snes_data_oe", 1'b0, snes_data_oe);
  endtask

  task automatic write_while_dead;
    wr_data[0] = 8'($random(seed));
    wr_data[1] = 8'($random(seed));
    mcu_write("dead write even", wr_addr, wr_data[0]);
    mcu_write("dead write odd", wr_addr_odd, wr_data[1]);
  endtask

  task automatic read_while_dead;
    mcu_read("dead read even", wr_addr, wr_data[0]);
    mcu_read("dead read odd", wr_addr_odd, wr_data[1]);
  endtask

  task automatic console_reads;
    @(posedge clk2);
    cpu_run <= 1'b1; // console comes alive
    mapper  <= snes_bus_pkg::lorom;
    console_read("lorom read", lo_addr, 1'b1, lorom_map(lo_addr));
    console_read("lorom miss", miss_addr, 1'b0, '0);
    @(posedge clk2);
    mapper <= snes_bus_pkg::hirom;
    console_read("hirom read", hi_addr, 1'b1, hirom_map(hi_addr));
  endtask

  task automatic read_while_live;
    int start_falls;
    start_falls = we_fall_count;
    fork
      mcu_read("live read", live_addr, model_byte(live_addr));
      console_traffic(4);
    join
    @(negedge clk2);
    n_checks++;
    if (we_fall_count != start_falls) begin
      err_count++;
      $display("rom_we fell %0d times during console reads", we_fall_count - start_falls);
    end
  endtask

  initial begin
    rst_n         = 1'b0;
    snes_addr_in  = '0;
    snes_read_in  = 1'b1; // strobes idle high
    snes_write_in = 1'b1;
    snes_data_in  = '0;
    mapper        = snes_bus_pkg::lorom;
    rom_mask      = test_mask;
    mcu_rrq       = 1'b0;
    mcu_wrq       = 1'b0;
    mcu_addr      = '0;
    mcu_dout      = '0;
    cpu_run       = 1'b0;
    err_count     = 0;
    n_checks      = 0;
    seed          = seed_init;
    repeat (4) @(posedge clk2);
    rst_n <= 1'b1;

    reset_values();
    write_while_dead();
    read_while_dead();
    console_reads();
    read_while_live();

    $display("checks: %0d, errors: %0d", n_checks, err_count);
    if (err_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_time);
    $display("watchdog: simulation still running after %0d time units", watchdog_time);
    $display("checks: %0d, errors: %0d", n_checks, err_count);
    $display("Something failed");
    $finish;
  end

endmodule
